/* aluDefs_defs.svh */
`ifndef ALUDEFS_DEFS_SVH
`define ALUDEFS_DEFS_SVH

// ==============================
// datapath sizes
// ==============================

// operand and result width of the execute stage
`define ALU_W 32

// width of the immediate shift amount field
`define SA_W 5

// ==============================
// multi-cycle engine timing
// ==============================

// one quotient bit is resolved per divider iteration
`define DIV_STEPS 32

// cycles from the start pulse to the multiply done pulse
`define MUL_CYCLES 4

`endif

/* aluPkg.sv */
`default_nettype none

`include "aluDefs_defs.svh"

package aluPkg;

    // ==============================
    // opcodes
    // ==============================
    typedef enum logic [4:0] {
        opAdd, opAddu, opSub, opSubu,
        opAnd, opOr, opNor, opXor,
        opSlt, opSltu,
        opSll, opSrl, opSra, opSllv, opSrlv, opSrav,
        opLui, opClz, opClo,
        opMult, opMultu, opDiv, opDivu,
        opMfhi, opMflo, opMthi, opMtlo
    } aluOp_e;

    // one issued operation as latched by the dispatcher
    typedef struct packed {
        aluOp_e            op;
        logic [`ALU_W-1:0] srcA;
        logic [`ALU_W-1:0] srcB;
        logic [`SA_W-1:0]  sa;
    } aluReq_t;

    // visible result of the unit, hi and lo are the architectural HI/LO pair
    typedef struct packed {
        logic [`ALU_W-1:0] value;
        logic              overflow;
        logic [`ALU_W-1:0] hi;
        logic [`ALU_W-1:0] lo;
    } aluRes_t;

    // ops that are handed to the multiply/divide engine
    function automatic logic isMulDiv(input aluOp_e op);
        return op inside {opMult, opMultu, opDiv, opDivu};
    endfunction

endpackage

`default_nettype wire

/* aluReqIf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

interface aluReqIf;

    aluPkg::aluReq_t   req;
    logic              startMd;

    logic [`ALU_W-1:0] aluValue;
    logic              aluOvf;

    logic [`ALU_W-1:0] mdHi;
    logic [`ALU_W-1:0] mdLo;
    logic              mdDone;

    // the dispatcher owns the request and collects both results
    modport dispatch (
        output req, startMd,
        input  aluValue, aluOvf, mdHi, mdLo, mdDone
    );

    modport alu (input req, output aluValue, aluOvf);

    modport md (input req, startMd, output mdHi, mdLo, mdDone);

endinterface

`default_nettype wire

/* intAlu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

module intAlu (
    aluReqIf.alu bus
);

    localparam int W = `ALU_W;

    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W:0]   wide;
    logic [W-1:0] value;
    logic         ovf;

    // number of leading bits equal to bitVal, 0 up to W
    function automatic logic [W-1:0] leadCount(input logic [W-1:0] v, input logic bitVal);
        logic [W-1:0] n;
        logic         stop;
        n = '0;
        stop = 1'b0;
        for (int i = W - 1; i >= 0; i--) begin
            if (!stop && (v[i] == bitVal)) begin
                n = n + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        return n;
    endfunction

    assign a = bus.req.srcA;
    assign b = bus.req.srcB;

    always_comb begin
        value = '0;
        ovf = 1'b0;
        wide = '0;
        case (bus.req.op)
            // signed forms widen by one bit so the carry out exposes overflow
            aluPkg::opAdd: begin
                wide = {a[W-1], a} + {b[W-1], b};
                value = wide[W-1:0];
                ovf = wide[W] ^ wide[W-1];
            end
            aluPkg::opSub: begin
                wide = {a[W-1], a} - {b[W-1], b};
                value = wide[W-1:0];
                ovf = wide[W] ^ wide[W-1];
            end
            aluPkg::opAddu: value = a + b;
            aluPkg::opSubu: value = a - b;

            aluPkg::opAnd:  value = a & b;
            aluPkg::opOr:   value = a | b;
            aluPkg::opNor:  value = ~(a | b);
            aluPkg::opXor:  value = a ^ b;

            aluPkg::opSlt:  value = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            aluPkg::opSltu: value = {{(W-1){1'b0}}, a < b};

            // shifts always move srcB, the amount comes from sa or from srcA
            aluPkg::opSll:  value = b << bus.req.sa;
            aluPkg::opSrl:  value = b >> bus.req.sa;
            aluPkg::opSra:  value = $signed(b) >>> bus.req.sa;
            aluPkg::opSllv: value = b << a[`SA_W-1:0];
            aluPkg::opSrlv: value = b >> a[`SA_W-1:0];
            aluPkg::opSrav: value = $signed(b) >>> a[`SA_W-1:0];

            aluPkg::opLui:  value = {b[W/2-1:0], {(W/2){1'b0}}};
            aluPkg::opClz:  value = leadCount(a, 1'b0);
            aluPkg::opClo:  value = leadCount(a, 1'b1);

            // mul/div and HI/LO moves are resolved by the result merge
            default:        value = '0;
        endcase

        // a real signed overflow leaves value with the sign opposite to srcA
        assert (!ovf || ((value[W-1] != a[W-1]) &&
                         (((bus.req.op == aluPkg::opAdd) && (a[W-1] == b[W-1])) ||
                          ((bus.req.op == aluPkg::opSub) && (a[W-1] != b[W-1])))))
            else $error("overflow raised without a signed overflow for op %0d", bus.req.op);
    end

    assign bus.aluValue = value;
    assign bus.aluOvf = ovf;

endmodule

`default_nettype wire

/* mulDivEngine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

module mulDivEngine (
    input wire   clk,
    input wire   rst_i,
    aluReqIf.md  bus
);

    localparam int W = `ALU_W;
    localparam int CHUNK = `ALU_W / `MUL_CYCLES;
    localparam int CNT_W = $clog2(`DIV_STEPS + 2);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             lastStep;

    logic             isDiv;
    logic             negRes;
    logic             negRem;
    logic             divZero;

    logic [2*W-1:0]   mcand;
    logic [2*W-1:0]   mulAcc;
    logic [2*W-1:0]   mulAccNext;
    logic [W-1:0]     mplier;

    logic [W-1:0]     rem;
    logic [W-1:0]     quo;
    logic [W-1:0]     dvsr;
    logic [W:0]       remShift;
    logic [W:0]       diff;

    logic             signedOp;
    logic             startDiv;
    logic             signA;
    logic             signB;
    logic [W-1:0]     magA;
    logic [W-1:0]     magB;

    // ==============================
    // operand preparation
    // ==============================
    // both units work on magnitudes and fix the signs in their last step
    assign signedOp = bus.req.op inside {aluPkg::opMult, aluPkg::opDiv};
    assign startDiv = bus.req.op inside {aluPkg::opDiv, aluPkg::opDivu};
    assign signA = signedOp & bus.req.srcA[W-1];
    assign signB = signedOp & bus.req.srcB[W-1];
    assign magA = signA ? -bus.req.srcA : bus.req.srcA;
    assign magB = signB ? -bus.req.srcB : bus.req.srcB;

    assign lastStep = (cnt == CNT_W'(1));

    // CHUNK multiplier bits are retired per cycle
    always_comb begin
        mulAccNext = mulAcc;
        for (int j = 0; j < CHUNK; j++) begin
            if (mplier[j]) begin
                mulAccNext = mulAccNext + (mcand << j);
            end
        end
    end

    // restoring step, the trial subtraction decides the next quotient bit
    assign remShift = {rem, quo[W-1]};
    assign diff = remShift - {1'b0, dvsr};

    // ==============================
    // sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy <= 1'b0;
            cnt <= '0;
            bus.mdDone <= 1'b0;
        end else begin
            bus.mdDone <= 1'b0;
            if (bus.startMd) begin
                busy <= 1'b1;
                cnt <= startDiv ? CNT_W'(`DIV_STEPS + 1) : CNT_W'(`MUL_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;
                    bus.mdDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.startMd) begin
            isDiv <= startDiv;
            negRes <= signA ^ signB;
            negRem <= signA;
            divZero <= (bus.req.srcB == '0);
            mcand <= {{W{1'b0}}, magA};
            mplier <= magB;
            mulAcc <= '0;
            rem <= '0;
            quo <= magA;
            dvsr <= magB;
        end else if (busy && !isDiv) begin
            mulAcc <= mulAccNext;
            mcand <= mcand << CHUNK;
            mplier <= mplier >> CHUNK;
            if (lastStep) begin
                {bus.mdHi, bus.mdLo} <= negRes ? -mulAccNext : mulAccNext;
            end
        end else if (busy && isDiv) begin
            if (!lastStep) begin
                if (!diff[W]) begin
                    rem <= diff[W-1:0];
                    quo <= {quo[W-2:0], 1'b1};
                end else begin
                    rem <= remShift[W-1:0];
                    quo <= {quo[W-2:0], 1'b0};
                end
            end else begin
                // the remainder follows the dividend, a zero divisor keeps it as is
                bus.mdLo <= divZero ? '1 : (negRes ? -quo : quo);
                bus.mdHi <= negRem ? -rem : rem;
            end
        end
    end

    // the dispatcher must wait for mdDone before issuing again
    assert property (@(posedge clk) disable iff (rst_i) bus.startMd |-> !busy)
        else $error("startMd while the mul/div engine is busy");

endmodule

`default_nettype wire

/* resultMerge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

module resultMerge (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  req_i,
    input  wire aluPkg::aluOp_e  op_i,
    input  wire [`ALU_W-1:0]     srcA_i,
    input  wire [`ALU_W-1:0]     srcB_i,
    input  wire [`SA_W-1:0]      sa_i,
    output logic                 ack_o,
    output logic [`ALU_W-1:0]    result_o,
    output logic                 overflow_o,
    output logic [`ALU_W-1:0]    hi_o,
    output logic [`ALU_W-1:0]    lo_o,
    aluReqIf.dispatch            bus
);

    typedef enum logic [1:0] {
        stIdle,
        stBusy,
        stAck
    } state_e;

    state_e            state;
    aluPkg::aluRes_t   res;
    logic [`ALU_W-1:0] selValue;
    logic              opDone;

    // ==============================
    // request latch
    // ==============================
    always_ff @(posedge clk) begin
        if ((state == stIdle) && req_i) begin
            bus.req <= '{op: op_i, srcA: srcA_i, srcB: srcB_i, sa: sa_i};
        end
    end

    // single-cycle ops finish one cycle after accept, mul/div wait for the engine
    assign opDone = !aluPkg::isMulDiv(bus.req.op) || bus.mdDone;

    always_comb begin
        case (bus.req.op)
            aluPkg::opMfhi: selValue = res.hi;
            aluPkg::opMflo: selValue = res.lo;
            aluPkg::opMthi,
            aluPkg::opMtlo: selValue = bus.req.srcA;
            default:        selValue = bus.aluValue;
        endcase
    end

    // ==============================
    // handshake FSM and HI/LO
    // ==============================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= stIdle;
            bus.startMd <= 1'b0;
            res <= '0;
        end else begin
            bus.startMd <= 1'b0;
            case (state)
                stIdle: begin
                    if (req_i) begin
                        bus.startMd <= aluPkg::isMulDiv(op_i);
                        // moves into HI/LO take effect on the accept edge
                        if (op_i == aluPkg::opMthi) begin
                            res.hi <= srcA_i;
                        end
                        if (op_i == aluPkg::opMtlo) begin
                            res.lo <= srcA_i;
                        end
                        state <= stBusy;
                    end
                end
                stBusy: begin
                    if (opDone) begin
                        res.value <= selValue;
                        res.overflow <= bus.aluOvf;
                        if (bus.mdDone) begin
                            res.hi <= bus.mdHi;
                            res.lo <= bus.mdLo;
                        end
                        state <= stAck;
                    end
                end
                stAck: begin
                    // a held req only keeps ack up, nothing new is started
                    if (!req_i) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign ack_o = (state == stAck);
    assign result_o = res.value;
    assign overflow_o = res.overflow;
    assign hi_o = res.hi;
    assign lo_o = res.lo;

    assert property (@(posedge clk) disable iff (rst_i) $rose(ack_o) |-> $past(req_i))
        else $error("ack_o raised without a pending request");

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

module execUnit (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  req_i,
    input  wire aluPkg::aluOp_e  op_i,
    input  wire [`ALU_W-1:0]     srcA_i,
    input  wire [`ALU_W-1:0]     srcB_i,
    input  wire [`SA_W-1:0]      sa_i,
    output logic                 ack_o,
    output logic [`ALU_W-1:0]    result_o,
    output logic                 overflow_o,
    output logic [`ALU_W-1:0]    hi_o,
    output logic [`ALU_W-1:0]    lo_o
);

    // shared by the dispatcher and both execution parts
    aluReqIf reqBus ();

    intAlu i_intAlu (
        .bus (reqBus.alu)
    );

    mulDivEngine i_mulDivEngine (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (reqBus.md)
    );

    resultMerge i_resultMerge (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .op_i       (op_i),
        .srcA_i     (srcA_i),
        .srcB_i     (srcB_i),
        .sa_i       (sa_i),
        .ack_o      (ack_o),
        .result_o   (result_o),
        .overflow_o (overflow_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o),
        .bus        (reqBus.dispatch)
    );

endmodule

`default_nettype wire

/* execUnit_checks.svh */
`ifndef EXECUNIT_CHECKS_SVH
`define EXECUNIT_CHECKS_SVH

    // ==============================
    // compare tasks
    // ==============================

    // result bus together with its overflow flag
    task automatic checkValue(input string what, input logic [`ALU_W-1:0] gotValue,
            input logic gotOvf, input logic [`ALU_W-1:0] expValue, input logic expOvf);
        checkCount++;
        if (gotValue !== expValue || gotOvf !== expOvf) begin
            errCount++;
            $display("MISMATCH at %0t: %s gave %h ovf %b, expected %h ovf %b",
                     $time, what, gotValue, gotOvf, expValue, expOvf);
        end
    endtask

    task automatic checkHiLo(input string what, input logic [`ALU_W-1:0] gotHi,
            input logic [`ALU_W-1:0] gotLo, input logic [`ALU_W-1:0] expHi,
            input logic [`ALU_W-1:0] expLo);
        checkCount++;
        if (gotHi !== expHi || gotLo !== expLo) begin
            errCount++;
            $display("MISMATCH at %0t: %s gave HI %h LO %h, expected HI %h LO %h",
                     $time, what, gotHi, gotLo, expHi, expLo);
        end
    endtask

    task automatic compareAck(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one line per finished test
    task automatic printTestLine(input string name, input int errsBefore);
        $display("test %-20s %s", name, (errCount == errsBefore) ? "ok" : "FAILED");
    endtask

    task automatic printTotals();
        $display("%0d checks, %0d errors", checkCount, errCount);
    endtask

`endif

/* execUnit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aluDefs_defs.svh"

module execUnit_tb;

    localparam int W = `ALU_W;
    localparam int SA_W = `SA_W;
    localparam int ACK_TIMEOUT = 200;

    logic            clk = 1'b0;
    logic            rst_i, req_i, ack_o, overflow_o;
    aluPkg::aluOp_e  op_i;
    logic [W-1:0]    srcA_i, srcB_i, result_o, hi_o, lo_o;
    logic [SA_W-1:0] sa_i;

    aluPkg::aluRes_t seen;
    logic [W-1:0]    modelHi, modelLo;
    logic            hung = 1'b0;
    int              errCount = 0;
    int              checkCount = 0;
    int              errBefore;

    execUnit i_execUnit (.*);

    always #5 clk = ~clk;

    `include "execUnit_checks.svh"

    // mostly random, with the corner values mixed in
    function automatic logic [W-1:0] pickOperand();
        case ($urandom % 8)
            0: return '0;
            1: return '1;
            2: return {1'b1, {(W-1){1'b0}}};
            3: return {1'b0, {(W-1){1'b1}}};
            default: return $urandom;
        endcase
    endfunction

    // ==============================
    // reference model
    // ==============================
    function automatic void aluModel(input aluPkg::aluOp_e op, input logic [W-1:0] a,
            input logic [W-1:0] b, input logic [SA_W-1:0] sa,
            output logic [W-1:0] v, output logic ovf);
        logic [SA_W-1:0] n;
        int lead;
        n = (op inside {aluPkg::opSllv, aluPkg::opSrlv, aluPkg::opSrav}) ? a[SA_W-1:0] : sa;
        lead = 0;
        case (op)
            aluPkg::opAdd, aluPkg::opAddu: v = a + b;
            aluPkg::opSub, aluPkg::opSubu: v = a - b;
            aluPkg::opAnd: v = a & b;
            aluPkg::opOr: v = a | b;
            aluPkg::opNor: v = ~(a | b);
            aluPkg::opXor: v = a ^ b;
            // a negative srcA is below any non-negative srcB
            aluPkg::opSlt: v = W'((a[W-1] != b[W-1]) ? a[W-1] : (a < b));
            aluPkg::opSltu: v = W'(a < b);
            aluPkg::opSll, aluPkg::opSllv: v = b << n;
            aluPkg::opSrl, aluPkg::opSrlv: v = b >> n;
            aluPkg::opSra, aluPkg::opSrav: v = (b >> n) | (b[W-1] ? ~({W{1'b1}} >> n) : '0);
            aluPkg::opLui: v = b << (W / 2);
            aluPkg::opClz, aluPkg::opClo: begin
                while (lead < W && a[W-1-lead] == (op == aluPkg::opClo)) begin
                    lead++;
                end
                v = W'(lead);
            end
            aluPkg::opMfhi: v = modelHi;
            aluPkg::opMflo: v = modelLo;
            default: v = a;
        endcase
        // signed overflow shows as a sum whose sign differs from both addends
        ovf = (op == aluPkg::opAdd) ? (a[W-1] == b[W-1]) && (v[W-1] != a[W-1]) :
              (op == aluPkg::opSub) ? (a[W-1] != b[W-1]) && (v[W-1] != a[W-1]) : 1'b0;
    endfunction

    // signed divide truncates toward zero and the remainder follows the dividend
    function automatic void mulDivModel(input aluPkg::aluOp_e op, input logic [W-1:0] a,
            input logic [W-1:0] b);
        logic         sgn;
        logic [W-1:0] ma, mb;
        sgn = op inside {aluPkg::opMult, aluPkg::opDiv};
        ma = (sgn && a[W-1]) ? -a : a;
        mb = (sgn && b[W-1]) ? -b : b;
        if (op inside {aluPkg::opMult, aluPkg::opMultu}) begin
            {modelHi, modelLo} = {{W{sgn & a[W-1]}}, a} * {{W{sgn & b[W-1]}}, b};
        end else if (b == '0) begin
            modelHi = a;
            modelLo = '1;
        end else begin
            modelHi = (sgn && a[W-1]) ? -(ma % mb) : ma % mb;
            modelLo = (sgn && (a[W-1] ^ b[W-1])) ? -(ma / mb) : ma / mb;
        end
    endfunction

    // ==============================
    // four-phase exchange
    // ==============================
    task automatic awaitAck(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack_o !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack_o !== level) begin
            $display("ERROR at %0t: ack_o did not go to %b within %0d cycles",
                     $time, level, ACK_TIMEOUT);
            hung = 1'b1;
            errCount++;
        end
    endtask

    task automatic handshake(input aluPkg::aluOp_e op, input logic [W-1:0] a,
            input logic [W-1:0] b, input logic [SA_W-1:0] sa, input int hold);
        @(posedge clk);
        req_i <= 1'b1;
        op_i <= op;
        srcA_i <= a;
        srcB_i <= b;
        sa_i <= sa;
        awaitAck(1'b1);
        seen = '{value: result_o, overflow: overflow_o, hi: hi_o, lo: lo_o};
        // a slow requester keeps req_i up and the result must not move meanwhile
        for (int i = 0; i < hold && !hung; i++) begin
            @(negedge clk);
            compareAck("ack_o while req_i held", ack_o, 1'b1);
            checkValue("result while req_i held", result_o, overflow_o,
                       seen.value, seen.overflow);
        end
        @(posedge clk);
        req_i <= 1'b0;
        if (!hung) begin
            awaitAck(1'b0);
        end
    endtask

    task automatic issueAndCompare(input aluPkg::aluOp_e op, input logic [W-1:0] a,
            input logic [W-1:0] b, input logic [SA_W-1:0] sa, input int hold);
        logic [W-1:0] v;
        logic         ovf;
        handshake(op, a, b, sa, hold);
        if (!hung) begin
            if (aluPkg::isMulDiv(op)) begin
                mulDivModel(op, a, b);
            end else begin
                aluModel(op, a, b, sa, v, ovf);
                checkValue(op.name(), seen.value, seen.overflow, v, ovf);
                modelHi = (op == aluPkg::opMthi) ? a : modelHi;
                modelLo = (op == aluPkg::opMtlo) ? a : modelLo;
            end
            checkHiLo(op.name(), seen.hi, seen.lo, modelHi, modelLo);
        end
    endtask

    initial begin
        void'($urandom(47143));
        rst_i <= 1'b1;
        req_i <= 1'b0;
        op_i <= aluPkg::opAdd;
        srcA_i <= '0;
        srcB_i <= '0;
        sa_i <= '0;
        modelHi = '0;
        modelLo = '0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        errBefore = errCount;
        @(negedge clk);
        compareAck("ack_o after reset", ack_o, 1'b0);
        checkHiLo("HI/LO after reset", hi_o, lo_o, '0, '0);
        printTestLine("reset values", errBefore);

        // the single-cycle opcodes are the first ones of the enum, up to opClo
        errBefore = errCount;
        for (int i = 0; i < 300 && !hung; i++) begin
            issueAndCompare(aluPkg::aluOp_e'($urandom % (aluPkg::opClo + 1)), pickOperand(),
                            pickOperand(), SA_W'($urandom), 0);
        end
        printTestLine("random ALU ops", errBefore);

        errBefore = errCount;
        for (int i = 0; i < 100 && !hung; i++) begin
            issueAndCompare($urandom % 2 ? aluPkg::opMult : aluPkg::opMultu, pickOperand(),
                            pickOperand(), '0, 0);
        end
        printTestLine("random mult/multu", errBefore);

        errBefore = errCount;
        for (int i = 0; i < 100 && !hung; i++) begin
            issueAndCompare($urandom % 2 ? aluPkg::opDiv : aluPkg::opDivu, pickOperand(),
                            ($urandom % 8 == 0) ? '0 : pickOperand(), '0, 0);
        end
        printTestLine("random div/divu", errBefore);

        // reads carry their own srcA so a pass-through of srcA cannot match HI or LO
        errBefore = errCount;
        issueAndCompare(aluPkg::opMthi, $urandom, '0, '0, 0);
        issueAndCompare(aluPkg::opMtlo, $urandom, '0, '0, 0);
        issueAndCompare(aluPkg::opMfhi, $urandom, '0, '0, 0);
        issueAndCompare(aluPkg::opMflo, $urandom, '0, '0, 0);
        issueAndCompare(aluPkg::opMult, $urandom, $urandom, '0, 0);
        printTestLine("HI/LO moves", errBefore);

        errBefore = errCount;
        issueAndCompare(aluPkg::opSub, pickOperand(), pickOperand(), '0, 6);
        repeat (3) begin
            @(negedge clk);
            compareAck("ack_o after release", ack_o, 1'b0);
        end
        issueAndCompare(aluPkg::opDivu, $urandom, $urandom, '0, 0);
        issueAndCompare(aluPkg::opAdd, pickOperand(), pickOperand(), '0, 0);
        printTestLine("held request", errBefore);

        printTotals();
        if (errCount == 0 && !hung) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
aluPkg.sv
aluReqIf.sv
intAlu.sv
mulDivEngine.sv
resultMerge.sv
execUnit.sv
execUnit_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module execUnit_tb \
    && ./obj_dir/VexecUnit_tb | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation run ok" || { echo "simulation run not ok"; exit 1; }
